// File: logic/drive_integrator.sv
module drive_integrator (
    input  logic                      i_ep50trig,
    input  logic                      i_reset_sim,
    input  reflex_pkg::epsc_set_t     i_epsc,
    input  reflex_pkg::gain_set_t     i_gains,
    input  reflex_pkg::cortex_drive_t i_cortex,
    output reflex_pkg::drive_t        o_drive
);

    import reflex_pkg::*;

    // scaled currents, one per synapse
    current_t sn_to_mn_s;
    current_t sn_to_cn_s;
    current_t sn_to_cn2_s;
    current_t cn_to_mn_s;
    current_t cn2_to_mn_s;
    // summed drives ahead of the latch
    drive_t   drive_d;
    drive_t   drive_q;

    //////////////////////////////////////////////////
    // synapse gain
    //////////////////////////////////////////////////
    // full product formed, only low word kept
    function automatic current_t scale(input current_t epsc, input gain_t gain);
        logic [CURRENT_W+GAIN_W-1:0] full;
        full = epsc * gain;
        return full[CURRENT_W-1:0];
    endfunction

    always_comb
    begin
        sn_to_mn_s  = scale(i_epsc.sn_to_mn, i_gains.sn_to_mn);
        // both cortical paths share the sn_to_cn gain
        sn_to_cn_s  = scale(i_epsc.sn_to_cn, i_gains.sn_to_cn);
        sn_to_cn2_s = scale(i_epsc.sn_to_cn2, i_gains.sn_to_cn);
        cn_to_mn_s  = scale(i_epsc.cn_to_mn, i_gains.cn_to_mn);
        cn2_to_mn_s = scale(i_epsc.cn2_to_mn, i_gains.cn2_to_mn);
    end

    //////////////////////////////////////////////////
    // current summation
    //////////////////////////////////////////////////
    always_comb
    begin
        // spinal plus both transcortical paths into mn
        drive_d.mn  = sn_to_mn_s + cn_to_mn_s + cn2_to_mn_s;
        // sensory input plus voluntary command
        drive_d.cn  = sn_to_cn_s + i_cortex.cn;
        drive_d.cn2 = sn_to_cn2_s + i_cortex.cn2;
    end

    //////////////////////////////////////////////////
    // drive latch
    //////////////////////////////////////////////////
    // one cycle latency, new value every clock
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            drive_q <= '0;
        end
        else
        begin
            drive_q <= drive_d;
        end
    end

    assign o_drive = drive_q;

endmodule

// File: logic/param_bank.sv
module param_bank (
    input  logic                      i_ep50trig,
    input  logic                      i_reset_sim,
    input  reflex_pkg::wb_req_t       i_wb,
    output reflex_pkg::wb_rsp_t       o_wb,
    output reflex_pkg::gain_set_t     o_gains,
    output reflex_pkg::cortex_drive_t o_cortex
);

    import reflex_pkg::*;

    // cycle pending while cyc and stb both high
    logic          pending;
    // accept on first pending edge with ack low
    logic          accept;
    logic          ack_q;
    wb_dat_t       rd_dat;
    gain_set_t     gains_q;
    cortex_drive_t cortex_q;

    //////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////
    assign pending = i_wb.cyc & i_wb.stb;
    assign accept  = pending & ~ack_q;

    // ack is a single pulse, one cycle after accept
    // master must drop stb before the next one
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= accept;
        end
    end

    //////////////////////////////////////////////////
    // parameter registers
    //////////////////////////////////////////////////
    // write lands on the ack edge
    // unmapped addresses dropped silently
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            gains_q.sn_to_mn  <= GAIN_RESET;
            gains_q.sn_to_cn  <= GAIN_RESET;
            gains_q.cn_to_mn  <= GAIN_RESET;
            gains_q.cn2_to_mn <= GAIN_RESET;
            cortex_q.cn       <= DRIVE_RESET;
            cortex_q.cn2      <= DRIVE_RESET;
        end
        else if (accept && i_wb.we)
        begin
            case (i_wb.adr)
                ADR_GAIN_SN_MN:  gains_q.sn_to_mn  <= i_wb.dat;
                ADR_GAIN_SN_CN:  gains_q.sn_to_cn  <= i_wb.dat;
                ADR_GAIN_CN_MN:  gains_q.cn_to_mn  <= i_wb.dat;
                ADR_GAIN_CN2_MN: gains_q.cn2_to_mn <= i_wb.dat;
                ADR_DRIVE_CN:    cortex_q.cn       <= i_wb.dat;
                ADR_DRIVE_CN2:   cortex_q.cn2      <= i_wb.dat;
                default:         ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // read back
    //////////////////////////////////////////////////
    // master holds adr through the ack cycle
    always_comb
    begin
        case (i_wb.adr)
            ADR_GAIN_SN_MN:  rd_dat = gains_q.sn_to_mn;
            ADR_GAIN_SN_CN:  rd_dat = gains_q.sn_to_cn;
            ADR_GAIN_CN_MN:  rd_dat = gains_q.cn_to_mn;
            ADR_GAIN_CN2_MN: rd_dat = gains_q.cn2_to_mn;
            ADR_DRIVE_CN:    rd_dat = cortex_q.cn;
            ADR_DRIVE_CN2:   rd_dat = cortex_q.cn2;
            // holes in the map read as zero
            default:         rd_dat = '0;
        endcase
    end

    // data bus quiet outside the ack cycle
    always_comb
    begin
        o_wb.ack = ack_q;
        o_wb.dat = ack_q ? rd_dat : '0;
    end

    assign o_gains  = gains_q;
    assign o_cortex = cortex_q;

endmodule

// File: logic/reflex_pkg.sv
package reflex_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    // synaptic currents and drives, integer units
    localparam int CURRENT_W = 32;
    localparam int GAIN_W    = 32;
    localparam int COUNT_W   = 32;
    // host register port
    localparam int WB_ADR_W  = 4;
    localparam int WB_DAT_W  = 32;
    // status leds on the board
    localparam int LED_W     = 8;

    // plain vectors, arithmetic wraps modulo 2^32
    typedef logic [CURRENT_W-1:0] current_t;
    typedef logic [GAIN_W-1:0]    gain_t;
    typedef logic [COUNT_W-1:0]   count_t;
    typedef logic [WB_ADR_W-1:0]  adr_t;
    typedef logic [WB_DAT_W-1:0]  wb_dat_t;
    typedef logic [LED_W-1:0]     led_t;

    //////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////
    localparam adr_t ADR_GAIN_SN_MN  = 4'd0;
    localparam adr_t ADR_GAIN_SN_CN  = 4'd1;
    localparam adr_t ADR_GAIN_CN_MN  = 4'd2;
    localparam adr_t ADR_GAIN_CN2_MN = 4'd3;
    localparam adr_t ADR_DRIVE_CN    = 4'd4;
    localparam adr_t ADR_DRIVE_CN2   = 4'd5;

    // unity gain, no cortical drive out of reset
    localparam gain_t    GAIN_RESET  = 32'd1;
    localparam current_t DRIVE_RESET = 32'd0;

    // led bit positions, active low
    localparam int LED_SN  = 0;
    localparam int LED_CN  = 1;
    localparam int LED_CN2 = 2;
    localparam int LED_MN  = 3;

    //////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////
    // wishbone classic, master to slave
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        adr_t    adr;
        wb_dat_t dat;
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    typedef struct packed {
        gain_t sn_to_mn;
        gain_t sn_to_cn;
        gain_t cn_to_mn;
        gain_t cn2_to_mn;
    } gain_set_t;

    // motor cortex direct drive
    typedef struct packed {
        current_t cn;
        current_t cn2;
    } cortex_drive_t;

    // unscaled postsynaptic currents
    typedef struct packed {
        current_t sn_to_mn;
        current_t sn_to_cn;
        current_t sn_to_cn2;
        current_t cn_to_mn;
        current_t cn2_to_mn;
    } epsc_set_t;

    typedef struct packed {
        current_t mn;
        current_t cn;
        current_t cn2;
    } drive_t;

    typedef struct packed {
        logic sn;
        logic cn;
        logic cn2;
        logic mn;
    } spike_t;

endpackage

// File: logic/reflex_top.sv
module reflex_top (
    input  logic                  i_ep50trig,
    input  logic                  i_reset_sim,
    // host register port
    input  reflex_pkg::wb_req_t   i_wb,
    output reflex_pkg::wb_rsp_t   o_wb,
    // from the neuron and synapse models
    input  reflex_pkg::epsc_set_t i_epsc,
    input  reflex_pkg::spike_t    i_spikes,
    // to the neuron models and the host
    output reflex_pkg::drive_t    o_drive,
    output reflex_pkg::count_t    o_sn_count,
    output reflex_pkg::count_t    o_mn_count,
    output reflex_pkg::led_t      o_led
);

    import reflex_pkg::*;

    // parameter bank to integrator
    gain_set_t     gains;
    cortex_drive_t cortex;

    //////////////////////////////////////////////////
    // host parameters
    //////////////////////////////////////////////////
    param_bank u_param_bank (
        .i_ep50trig  (i_ep50trig),
        .i_reset_sim (i_reset_sim),
        .i_wb        (i_wb),
        .o_wb        (o_wb),
        .o_gains     (gains),
        .o_cortex    (cortex)
    );

    //////////////////////////////////////////////////
    // spinal and cortical drive
    //////////////////////////////////////////////////
    // gain writes reach o_drive one edge after ack
    drive_integrator u_drive_integrator (
        .i_ep50trig  (i_ep50trig),
        .i_reset_sim (i_reset_sim),
        .i_epsc      (i_epsc),
        .i_gains     (gains),
        .i_cortex    (cortex),
        .o_drive     (o_drive)
    );

    //////////////////////////////////////////////////
    // spike status
    //////////////////////////////////////////////////
    // raw spikes straight in
    spike_monitor u_spike_monitor (
        .i_ep50trig  (i_ep50trig),
        .i_reset_sim (i_reset_sim),
        .i_spikes    (i_spikes),
        .o_sn_count  (o_sn_count),
        .o_mn_count  (o_mn_count),
        .o_led       (o_led)
    );

endmodule

// File: logic/spike_monitor.sv
module spike_monitor (
    input  logic               i_ep50trig,
    input  logic               i_reset_sim,
    input  reflex_pkg::spike_t i_spikes,
    output reflex_pkg::count_t o_sn_count,
    output reflex_pkg::count_t o_mn_count,
    output reflex_pkg::led_t   o_led
);

    import reflex_pkg::*;

    count_t sn_count_q;
    count_t mn_count_q;
    led_t   led_d;
    led_t   led_q;

    // spare leds stay dark
    always_comb
    begin
        led_d          = '1;
        led_d[LED_SN]  = ~i_spikes.sn;
        led_d[LED_CN]  = ~i_spikes.cn;
        led_d[LED_CN2] = ~i_spikes.cn2;
        led_d[LED_MN]  = ~i_spikes.mn;
    end

    //////////////////////////////////////////////////
    // counters and led register
    //////////////////////////////////////////////////
    // one count per cycle with spike high, wraps at 2^32
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            sn_count_q <= '0;
            mn_count_q <= '0;
            // all leds off
            led_q      <= '1;
        end
        else
        begin
            if (i_spikes.sn)
            begin
                sn_count_q <= sn_count_q + 1'b1;
            end
            if (i_spikes.mn)
            begin
                mn_count_q <= mn_count_q + 1'b1;
            end
            led_q <= led_d;
        end
    end

    assign o_sn_count = sn_count_q;
    assign o_mn_count = mn_count_q;
    assign o_led      = led_q;

endmodule

// File: reflex_loop.f
logic/reflex_pkg.sv
logic/param_bank.sv
logic/drive_integrator.sv
logic/spike_monitor.sv
logic/reflex_top.sv
sim/reflex_assertions.sv
sim/tb_reflex_top.sv

// File: sim/reflex_assertions.sv
module reflex_assertions (
    input  logic                  i_ep50trig,
    input  logic                  i_reset_sim,
    input  reflex_pkg::wb_req_t   i_wb,
    input  reflex_pkg::wb_rsp_t   i_wb_rsp,
    input  reflex_pkg::epsc_set_t i_epsc,
    input  reflex_pkg::spike_t    i_spikes,
    input  reflex_pkg::drive_t    i_drive,
    input  reflex_pkg::count_t    i_sn_count,
    input  reflex_pkg::count_t    i_mn_count,
    input  reflex_pkg::led_t      i_led
);

    import reflex_pkg::*;

    // read by the testbench at the end of the run
    int            fail_count = 0;
    logic          pending;
    gain_set_t     shadow_gains;
    cortex_drive_t shadow_cortex;
    drive_t        expected_drive;

    assign pending = i_wb.cyc & i_wb.stb;

    //////////////////////////////////////////////////
    // shadow of the parameter bank
    //////////////////////////////////////////////////
    // write lands on the edge that raises ack
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            shadow_gains  <= {4{32'd1}};
            shadow_cortex <= '0;
        end
        else if (pending && !i_wb_rsp.ack && i_wb.we)
        begin
            case (i_wb.adr)
                ADR_GAIN_SN_MN:  shadow_gains.sn_to_mn  <= i_wb.dat;
                ADR_GAIN_SN_CN:  shadow_gains.sn_to_cn  <= i_wb.dat;
                ADR_GAIN_CN_MN:  shadow_gains.cn_to_mn  <= i_wb.dat;
                ADR_GAIN_CN2_MN: shadow_gains.cn2_to_mn <= i_wb.dat;
                ADR_DRIVE_CN:    shadow_cortex.cn       <= i_wb.dat;
                ADR_DRIVE_CN2:   shadow_cortex.cn2      <= i_wb.dat;
                default:         ;
            endcase
        end
    end

    // reference drives, low 32 bits of every product
    always_comb
    begin
        expected_drive.mn  = i_epsc.sn_to_mn * shadow_gains.sn_to_mn
                           + i_epsc.cn_to_mn * shadow_gains.cn_to_mn
                           + i_epsc.cn2_to_mn * shadow_gains.cn2_to_mn;
        // both cortical paths scaled by sn_to_cn
        expected_drive.cn  = i_epsc.sn_to_cn * shadow_gains.sn_to_cn + shadow_cortex.cn;
        expected_drive.cn2 = i_epsc.sn_to_cn2 * shadow_gains.sn_to_cn + shadow_cortex.cn2;
    end

    //////////////////////////////////////////////////
    // bus handshake
    //////////////////////////////////////////////////
    ack_after_request: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        pending && !i_wb_rsp.ack |=> i_wb_rsp.ack)
        else begin fail_count++; $error("no ack one cycle after a pending request"); end

    ack_single_pulse: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        i_wb_rsp.ack |=> !i_wb_rsp.ack)
        else begin fail_count++; $error("ack held high on two cycles in a row"); end

    // holes above the last register
    unmapped_reads_zero: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        i_wb_rsp.ack && !i_wb.we && (i_wb.adr > ADR_DRIVE_CN2) |-> i_wb_rsp.dat == '0)
        else begin fail_count++; $error("unmapped read returned nonzero data"); end

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////
    drive_rule: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        !$past(i_reset_sim) |-> i_drive == $past(expected_drive))
        else begin fail_count++; $error("drive differs from scaled current sum"); end

    count_rule: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        !$past(i_reset_sim) |->
            (i_sn_count == count_t'($past(i_sn_count) + $past(i_spikes.sn))) &&
            (i_mn_count == count_t'($past(i_mn_count) + $past(i_spikes.mn))))
        else begin fail_count++; $error("spike count did not follow its input"); end

    // spare leds stay dark
    led_rule: assert property (@(posedge i_ep50trig) disable iff (i_reset_sim)
        !$past(i_reset_sim) |->
            i_led == {4'hf, ~$past(i_spikes.mn), ~$past(i_spikes.cn2),
                      ~$past(i_spikes.cn), ~$past(i_spikes.sn)})
        else begin fail_count++; $error("led pattern wrong for last spikes"); end

endmodule

bind reflex_top reflex_assertions u_reflex_assertions (
    .i_ep50trig  (i_ep50trig),
    .i_reset_sim (i_reset_sim),
    .i_wb        (i_wb),
    .i_wb_rsp    (o_wb),
    .i_epsc      (i_epsc),
    .i_spikes    (i_spikes),
    .i_drive     (o_drive),
    .i_sn_count  (o_sn_count),
    .i_mn_count  (o_mn_count),
    .i_led       (o_led)
);

// File: sim/tb_reflex_top.sv
module tb_reflex_top;

    import reflex_pkg::*;

    localparam int          CLK_HALF      = 2;
    localparam int          DRIVE_DELAY   = 1;
    localparam int          RESET_CYCLES  = 10;
    localparam int          RANDOM_CYCLES = 400;
    // about four times reset, bus traffic and random phase
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] RANDOM_SEED    = 32'h08abadcc;

    logic      ep50trig;
    logic      reset_sim;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    epsc_set_t epsc;
    spike_t    spikes;
    drive_t    drive;
    count_t    sn_count;
    count_t    mn_count;
    led_t      led;

    logic      stim_on;
    int        error_count = 0;
    int        cycle_count = 0;
    // spikes handed to the DUT so far
    count_t    sn_sent = '0;
    count_t    mn_sent = '0;
    wb_dat_t   wr_values [6];

    reflex_top u_reflex_top (
        .i_ep50trig  (ep50trig),
        .i_reset_sim (reset_sim),
        .i_wb        (wb_req),
        .o_wb        (wb_rsp),
        .i_epsc      (epsc),
        .i_spikes    (spikes),
        .o_drive     (drive),
        .o_sn_count  (sn_count),
        .o_mn_count  (mn_count),
        .o_led       (led)
    );

    always #(CLK_HALF) ep50trig = ~ep50trig;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic wait_cycle();
        @(posedge ep50trig);
        #(DRIVE_DELAY);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // classic cycle, held through the ack cycle, then one idle cycle
    task automatic bus_access(input logic we, input adr_t adr, input wb_dat_t wdat,
                              output wb_dat_t rdat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do
        begin
            wait_cycle();
        end
        while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        // request stays up until the edge that closes the ack cycle
        wait_cycle();
        wb_req = '0;
        wait_cycle();
    endtask

    task automatic report_and_stop(input logic timed_out);
        int assert_fails;
        assert_fails = u_reflex_top.u_reflex_assertions.fail_count;
        $display("check errors %0d, assertion failures %0d", error_count, assert_fails);
        if (!timed_out && error_count == 0 && assert_fails == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // background stimulus
    //////////////////////////////////////////////////
    // enable sampled at the edge, inputs change just after
    always @(posedge ep50trig)
    begin
        logic [31:0] rnd;
        if (stim_on)
        begin
            #(DRIVE_DELAY);
            epsc.sn_to_mn  = $urandom();
            epsc.sn_to_cn  = $urandom();
            epsc.sn_to_cn2 = $urandom();
            epsc.cn_to_mn  = $urandom();
            epsc.cn2_to_mn = $urandom();
            rnd            = $urandom();
            spikes         = rnd[3:0];
            sn_sent        = sn_sent + spikes.sn;
            mn_sent        = mn_sent + spikes.mn;
        end
        else
        begin
            #(DRIVE_DELAY);
            epsc   = '0;
            spikes = '0;
        end
    end

    always @(posedge ep50trig)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout, run still busy after %0d cycles", cycle_count);
            report_and_stop(1'b1);
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial
    begin
        wb_dat_t     rdat;
        logic [31:0] seed_ret;
        seed_ret  = $urandom(RANDOM_SEED);
        ep50trig  = 1'b0;
        reset_sim = 1'b1;
        wb_req    = '0;
        epsc      = '0;
        spikes    = '0;
        stim_on   = 1'b0;
        repeat (RESET_CYCLES) @(posedge ep50trig);
        #(DRIVE_DELAY);
        reset_sim = 1'b0;
        wait_cycle();

        // outputs straight out of reset
        check_value("reset ack", 32'd0, wb_rsp.ack);
        check_value("reset drive mn", 32'd0, drive.mn);
        check_value("reset drive cn", 32'd0, drive.cn);
        check_value("reset drive cn2", 32'd0, drive.cn2);
        check_value("reset sn count", 32'd0, sn_count);
        check_value("reset mn count", 32'd0, mn_count);
        check_value("reset leds", 32'h0000_00ff, led);

        // unity gains, then zero cortical drives
        for (int i = 0; i < 6; i++)
        begin
            bus_access(1'b0, adr_t'(i), '0, rdat);
            check_value($sformatf("default adr %0d", i), (i < 4) ? 32'd1 : 32'd0, rdat);
        end
        bus_access(1'b0, 4'd9, '0, rdat);
        check_value("unmapped read", 32'd0, rdat);

        // writes land while currents move
        stim_on = 1'b1;
        for (int i = 0; i < 6; i++)
        begin
            wr_values[i] = $urandom();
            bus_access(1'b1, adr_t'(i), wr_values[i], rdat);
        end
        for (int i = 0; i < 6; i++)
        begin
            bus_access(1'b0, adr_t'(i), '0, rdat);
            check_value($sformatf("read back adr %0d", i), wr_values[i], rdat);
        end

        // random phase with an occasional gain change
        for (int c = 0; c < RANDOM_CYCLES; c++)
        begin
            if (c % 100 == 50)
            begin
                bus_access(1'b1, adr_t'($urandom_range(0, 5)), $urandom(), rdat);
            end
            else
            begin
                wait_cycle();
            end
        end

        // let the last spikes reach the counters
        stim_on = 1'b0;
        repeat (3) wait_cycle();
        check_value("final sn count", sn_sent, sn_count);
        check_value("final mn count", mn_sent, mn_count);
        report_and_stop(1'b0);
    end

endmodule
